// ==== design/ladder_macros.svh ====
`ifndef LADDER_MACROS_SVH
`define LADDER_MACROS_SVH

// grid and sprite words
`define COORD_W         7
`define COLOUR_W        3
`define X_WRAP          126     // last column, then back to 0
`define TOP_ROW         26      // goal row
`define NUM_MINIONS     6

// player start
`define PLAYER_X0       5
`define PLAYER_Y0       117

// ladder spans: column, then down and up row bounds
`define LADDER_BOT_X        126
`define LADDER_BOT_DN_LO    85
`define LADDER_BOT_DN_HI    116
`define LADDER_BOT_UP_LO    86
`define LADDER_BOT_UP_HI    117
`define LADDER_MID_X        16
`define LADDER_MID_DN_LO    56
`define LADDER_MID_DN_HI    84
`define LADDER_MID_UP_LO    57
`define LADDER_MID_UP_HI    86
`define LADDER_TOP_X        126
`define LADDER_TOP_DN_LO    26
`define LADDER_TOP_DN_HI    55
`define LADDER_TOP_UP_LO    27
`define LADDER_TOP_UP_HI    61

// move timing
`define TICK_PERIOD     64
`define PHASE_STEP      8       // keeps sprite plots apart
`define SCORE_MAX       31

`endif

// ==== design/ladder_pkg.sv ====
`include "ladder_macros.svh"

package ladder_pkg;

    typedef logic [`COORD_W-1:0]  coord_t;
    typedef logic [`COLOUR_W-1:0] colour_t;

    localparam colour_t COLOUR_BLACK  = 3'b000;
    localparam colour_t COLOUR_PLAYER = 3'b010;   // green
    localparam colour_t COLOUR_MINION = 3'b100;   // red

    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_RIGHT,
        DIR_LEFT,
        DIR_DOWN,
        DIR_UP
    } dir_t;

    // sprite plot sequence
    typedef enum logic [1:0] {
        MV_IDLE,
        MV_ERASE,
        MV_DRAW
    } move_state_t;

    // one column step with wrap at X_WRAP
    function automatic coord_t step_x(coord_t x, dir_t dir);
        coord_t nx;
        nx = x;
        if (dir == DIR_RIGHT)
            nx = (x == coord_t'(`X_WRAP)) ? '0 : x + 1'b1;
        else if (dir == DIR_LEFT)
            nx = (x == '0) ? coord_t'(`X_WRAP) : x - 1'b1;
        return nx;
    endfunction

endpackage

// ==== design/plot_if.sv ====
`timescale 1ns/1ps

interface plot_if import ladder_pkg::*; ();

    logic    plot;      // one-cycle write strobe
    coord_t  x;
    coord_t  y;
    colour_t colour;

    modport source
    (
        output plot,
        output x,
        output y,
        output colour
    );

    modport sink
    (
        input plot,
        input x,
        input y,
        input colour
    );

endinterface

// ==== design/tick_gen.sv ====
`timescale 1ns/1ps
`include "ladder_macros.svh"

module tick_gen #(
    parameter int PHASE = 0
)
(
    input  logic clk,
    input  logic reset_n,
    output logic tick
);

    localparam int CNT_W = $clog2(`TICK_PERIOD);
    localparam logic [CNT_W-1:0] CNT_LAST  = CNT_W'(`TICK_PERIOD - 1);
    localparam logic [CNT_W-1:0] CNT_START = CNT_W'(`TICK_PERIOD - 1 - PHASE);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cnt  <= CNT_START;  // phase offset from the wrap
            tick <= 1'b0;
        end
        else
        begin
            cnt  <= (cnt == CNT_LAST) ? '0 : cnt + 1'b1;
            tick <= (cnt == CNT_LAST);
        end
    end

endmodule

// ==== design/player_mover.sv ====
`timescale 1ns/1ps
`include "ladder_macros.svh"

module player_mover import ladder_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic [3:0] key,         // active low
    input  logic       restart,
    output coord_t     pos_x,
    output coord_t     pos_y,
    plot_if.source     pix
);

    move_state_t state;
    dir_t        key_dir;
    dir_t        dir_q;     // direction taken at the tick
    logic        tick;
    logic        can_down;
    logic        can_up;
    coord_t      next_x;
    coord_t      next_y;

    function automatic logic in_span(coord_t x, coord_t y, int col, int lo, int hi);
        return (x == coord_t'(col)) && (y >= coord_t'(lo)) && (y <= coord_t'(hi));
    endfunction

    tick_gen #(
        .PHASE (0)
    ) i_tick_gen (
        .clk     (clk),
        .reset_n (reset_n),
        .tick    (tick)
    );

    // fixed key priority
    always_comb
    begin
        key_dir = DIR_NONE;
        if (!key[0])
            key_dir = DIR_RIGHT;
        else if (!key[3])
            key_dir = DIR_LEFT;
        else if (!key[1])
            key_dir = DIR_DOWN;
        else if (!key[2])
            key_dir = DIR_UP;
    end

    // vertical moves only on a ladder
    assign can_down = in_span(pos_x, pos_y, `LADDER_BOT_X, `LADDER_BOT_DN_LO, `LADDER_BOT_DN_HI)
                   || in_span(pos_x, pos_y, `LADDER_MID_X, `LADDER_MID_DN_LO, `LADDER_MID_DN_HI)
                   || in_span(pos_x, pos_y, `LADDER_TOP_X, `LADDER_TOP_DN_LO, `LADDER_TOP_DN_HI);
    assign can_up   = in_span(pos_x, pos_y, `LADDER_BOT_X, `LADDER_BOT_UP_LO, `LADDER_BOT_UP_HI)
                   || in_span(pos_x, pos_y, `LADDER_MID_X, `LADDER_MID_UP_LO, `LADDER_MID_UP_HI)
                   || in_span(pos_x, pos_y, `LADDER_TOP_X, `LADDER_TOP_UP_LO, `LADDER_TOP_UP_HI);

    always_comb
    begin
        next_x = step_x(pos_x, dir_q);
        next_y = pos_y;     // blocked moves keep y
        if (dir_q == DIR_DOWN && can_down)
            next_y = pos_y + 1'b1;
        else if (dir_q == DIR_UP && can_up)
            next_y = pos_y - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= MV_IDLE;
            dir_q <= DIR_NONE;
            pos_x <= coord_t'(`PLAYER_X0);
            pos_y <= coord_t'(`PLAYER_Y0);
        end
        else if (restart)
        begin
            state <= MV_IDLE;   // back to start, no plot
            pos_x <= coord_t'(`PLAYER_X0);
            pos_y <= coord_t'(`PLAYER_Y0);
        end
        else
        begin
            case (state)
                MV_IDLE:
                begin
                    if (tick && key_dir != DIR_NONE)
                    begin
                        state <= MV_ERASE;
                        dir_q <= key_dir;
                    end
                end
                MV_ERASE:
                begin
                    state <= MV_DRAW;
                    pos_x <= next_x;
                    pos_y <= next_y;
                end
                default:
                    state <= MV_IDLE;
            endcase
        end
    end

    assign pix.plot   = (state != MV_IDLE);
    assign pix.x      = pos_x;
    assign pix.y      = pos_y;
    assign pix.colour = (state == MV_DRAW) ? COLOUR_PLAYER : COLOUR_BLACK;

endmodule

// ==== design/minion_lane.sv ====
`timescale 1ns/1ps

module minion_lane import ladder_pkg::*; #(
    parameter coord_t START_X = '0,
    parameter coord_t START_Y = '0,
    parameter dir_t   DIR     = DIR_RIGHT,
    parameter int     PHASE   = 0
)
(
    input  logic   clk,
    input  logic   reset_n,
    output coord_t pos_x,
    output coord_t pos_y,
    plot_if.source pix
);

    move_state_t state;
    logic        tick;

    tick_gen #(
        .PHASE (PHASE)
    ) i_tick_gen (
        .clk     (clk),
        .reset_n (reset_n),
        .tick    (tick)
    );

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= MV_IDLE;
            pos_x <= START_X;
        end
        else
        begin
            case (state)
                MV_IDLE:
                    state <= tick ? MV_ERASE : MV_IDLE;
                MV_ERASE:
                begin
                    state <= MV_DRAW;
                    pos_x <= step_x(pos_x, DIR);    // new column shows with the draw
                end
                default:
                    state <= MV_IDLE;
            endcase
        end
    end

    assign pos_y = START_Y;    // lane row never changes

    assign pix.plot   = (state != MV_IDLE);
    assign pix.x      = pos_x;
    assign pix.y      = pos_y;
    assign pix.colour = (state == MV_DRAW) ? COLOUR_MINION : COLOUR_BLACK;

endmodule

// ==== design/plot_arbiter.sv ====
`timescale 1ns/1ps
`include "ladder_macros.svh"

module plot_arbiter import ladder_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    plot_if.sink    player,
    plot_if.sink    minion [`NUM_MINIONS],
    output logic    plot,
    output coord_t  x,
    output coord_t  y,
    output colour_t colour
);

    logic    req     [`NUM_MINIONS];
    coord_t  req_x   [`NUM_MINIONS];
    coord_t  req_y   [`NUM_MINIONS];
    colour_t req_col [`NUM_MINIONS];
    logic    sel_plot;
    coord_t  sel_x;
    coord_t  sel_y;
    colour_t sel_colour;

    // one request slot per minion lane
    for (genvar k = 0; k < `NUM_MINIONS; k++)
    begin : g_req
        assign req[k]     = minion[k].plot;
        assign req_x[k]   = minion[k].x;
        assign req_y[k]   = minion[k].y;
        assign req_col[k] = minion[k].colour;
    end

    always_comb
    begin
        sel_plot   = player.plot;
        sel_x      = player.x;
        sel_y      = player.y;
        sel_colour = player.colour;
        if (!player.plot)
        begin
            // walk down so minion 0 wins
            for (int k = `NUM_MINIONS - 1; k >= 0; k--)
            begin
                if (req[k])
                begin
                    sel_plot   = 1'b1;
                    sel_x      = req_x[k];
                    sel_y      = req_y[k];
                    sel_colour = req_col[k];
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            plot <= 1'b0;
        else
            plot <= sel_plot;
    end

    always_ff @(posedge clk)
    begin
        x      <= sel_x;
        y      <= sel_y;
        colour <= sel_colour;
    end

endmodule

// ==== design/score_keeper.sv ====
`timescale 1ns/1ps
`include "ladder_macros.svh"

module score_keeper import ladder_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  coord_t     player_x,
    input  coord_t     player_y,
    input  coord_t     minion_x [`NUM_MINIONS],
    input  coord_t     minion_y [`NUM_MINIONS],
    output logic       restart,
    output logic [6:0] hex0,    // units
    output logic [6:0] hex1     // tens
);

    localparam int SCORE_W = $clog2(`SCORE_MAX + 1);

    logic [SCORE_W-1:0] score;
    logic               at_top;
    logic               hit;
    logic [3:0]         tens;
    logic [3:0]         units;

    // active-low segments, g in bit 6
    function automatic logic [6:0] seg7(logic [3:0] digit);
        case (digit)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0011000;
            default: return 7'b1111111;     // blank
        endcase
    endfunction

    assign at_top = (player_y == coord_t'(`TOP_ROW));

    always_comb
    begin
        hit = 1'b0;
        for (int k = 0; k < `NUM_MINIONS; k++)
            if (player_x == minion_x[k] && player_y == minion_y[k])
                hit = 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            score   <= '0;
            restart <= 1'b0;
        end
        else
        begin
            restart <= 1'b0;
            // player still sits on the old spot while restart is high
            if (!restart)
            begin
                if (at_top)
                begin
                    restart <= 1'b1;
                    if (score != SCORE_W'(`SCORE_MAX))
                        score <= score + 1'b1;
                end
                else if (hit)
                begin
                    restart <= 1'b1;
                    score   <= '0;
                end
            end
        end
    end

    assign tens  = 4'(score / 10);
    assign units = 4'(score % 10);
    assign hex0  = seg7(units);
    assign hex1  = seg7(tens);

endmodule

// ==== design/ladder_game_top.sv ====
`timescale 1ns/1ps
`include "ladder_macros.svh"

module ladder_game_top import ladder_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic [3:0] key,
    output logic       plot,
    output coord_t     x,
    output coord_t     y,
    output colour_t    colour,
    output logic [6:0] hex0,
    output logic [6:0] hex1
);

    // minion lanes, index 0 first
    localparam coord_t MINION_X0  [`NUM_MINIONS] = '{47, 48, 36, 83, 81, 56};
    localparam coord_t MINION_Y0  [`NUM_MINIONS] = '{42, 36, 70, 82, 97, 107};
    localparam dir_t   MINION_DIR [`NUM_MINIONS] =
        '{DIR_RIGHT, DIR_LEFT, DIR_RIGHT, DIR_RIGHT, DIR_LEFT, DIR_RIGHT};

    coord_t player_x;
    coord_t player_y;
    coord_t minion_x [`NUM_MINIONS];
    coord_t minion_y [`NUM_MINIONS];
    logic   restart;

    plot_if player_pix ();
    plot_if minion_pix [`NUM_MINIONS] ();

    player_mover i_player_mover (
        .clk     (clk),
        .reset_n (reset_n),
        .key     (key),
        .restart (restart),
        .pos_x   (player_x),
        .pos_y   (player_y),
        .pix     (player_pix)
    );

    for (genvar k = 0; k < `NUM_MINIONS; k++)
    begin : g_minion
        minion_lane #(
            .START_X (MINION_X0[k]),
            .START_Y (MINION_Y0[k]),
            .DIR     (MINION_DIR[k]),
            .PHASE   ((k + 1) * `PHASE_STEP)   // player owns phase 0
        ) i_minion_lane (
            .clk     (clk),
            .reset_n (reset_n),
            .pos_x   (minion_x[k]),
            .pos_y   (minion_y[k]),
            .pix     (minion_pix[k])
        );
    end

    score_keeper i_score_keeper (
        .clk      (clk),
        .reset_n  (reset_n),
        .player_x (player_x),
        .player_y (player_y),
        .minion_x (minion_x),
        .minion_y (minion_y),
        .restart  (restart),
        .hex0     (hex0),
        .hex1     (hex1)
    );

    plot_arbiter i_plot_arbiter (
        .clk     (clk),
        .reset_n (reset_n),
        .player  (player_pix),
        .minion  (minion_pix),
        .plot    (plot),
        .x       (x),
        .y       (y),
        .colour  (colour)
    );

endmodule

// ==== tb/game_checker.sv ====
`timescale 1ns/1ps
`include "ladder_macros.svh"

module game_checker import ladder_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic [3:0] key,
    input  logic       plot,
    input  coord_t     x,
    input  coord_t     y,
    input  colour_t    colour,
    input  logic [6:0] hex0,
    input  logic [6:0] hex1,
    input  coord_t     player_x,
    input  coord_t     player_y,
    input  logic       case_end,
    input  int         case_num,
    input  int         exp_x,
    input  int         exp_y,
    input  int         exp_score,
    output int         pass_cnt,
    output int         fail_cnt
);

    localparam int NUM = `NUM_MINIONS;
    localparam int MX0 [NUM] = '{47, 48, 36, 83, 81, 56};
    localparam int MY0 [NUM] = '{42, 36, 70, 82, 97, 107};
    localparam int MDIR [NUM] = '{1, -1, 1, 1, -1, 1};   // +1 right

    int         n;          // cycles since reset release
    int         px;
    int         py;
    int         pdir;       // 0 none, 1 right, 2 left, 3 down, 4 up
    int         score;
    int         mx [NUM];
    int         errs;
    logic       pair_on;
    logic       rst_q;
    logic [3:0] key_q;
    logic       end_q;
    int         num_q;
    int         ex_q;
    int         ey_q;
    int         es_q;

    function automatic int wrap_step(int v, int d);
        if (d > 0)
            return (v == `X_WRAP) ? 0 : v + 1;
        if (d < 0)
            return (v == 0) ? `X_WRAP : v - 1;
        return v;
    endfunction

    function automatic logic on_span(int cx, int cy, int col, int lo, int hi);
        return (cx == col) && (cy >= lo) && (cy <= hi);
    endfunction

    function automatic logic may_descend(int cx, int cy);
        return on_span(cx, cy, `LADDER_BOT_X, `LADDER_BOT_DN_LO, `LADDER_BOT_DN_HI)
            || on_span(cx, cy, `LADDER_MID_X, `LADDER_MID_DN_LO, `LADDER_MID_DN_HI)
            || on_span(cx, cy, `LADDER_TOP_X, `LADDER_TOP_DN_LO, `LADDER_TOP_DN_HI);
    endfunction

    function automatic logic may_climb(int cx, int cy);
        return on_span(cx, cy, `LADDER_BOT_X, `LADDER_BOT_UP_LO, `LADDER_BOT_UP_HI)
            || on_span(cx, cy, `LADDER_MID_X, `LADDER_MID_UP_LO, `LADDER_MID_UP_HI)
            || on_span(cx, cy, `LADDER_TOP_X, `LADDER_TOP_UP_LO, `LADDER_TOP_UP_HI);
    endfunction

    // active-low segments, g on bit 6
    function automatic logic [6:0] seg_for(int digit);
        case (digit)
            0: return 7'h40;
            1: return 7'h79;
            2: return 7'h24;
            3: return 7'h30;
            4: return 7'h19;
            5: return 7'h12;
            6: return 7'h02;
            7: return 7'h78;
            8: return 7'h00;
            9: return 7'h18;
            default: return 7'h7f;
        endcase
    endfunction

    task automatic value_error(string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        errs++;
    endtask

    task automatic plain_error(string msg);
        $display("error at %0d ns: %s", $time, msg);
        errs++;
    endtask

    task automatic restart_player();
        px = `PLAYER_X0;
        py = `PLAYER_Y0;
    endtask

    // goal first, then minion contact
    task automatic apply_rules();
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < NUM; k++)
            if (px == mx[k] && py == MY0[k])
                hit = 1'b1;
        if (py == `TOP_ROW)
        begin
            if (score < `SCORE_MAX)
                score++;
            restart_player();
        end
        else if (hit)
        begin
            score = 0;
            restart_player();
        end
    endtask

    task automatic check_erase(int sprite);
        int ex;
        int ey;
        ex = (sprite == 0) ? px : mx[sprite-1];
        ey = (sprite == 0) ? py : MY0[sprite-1];
        if (sprite == 0)
        begin
            pdir = 0;
            if (!key_q[0])
                pdir = 1;
            else if (!key_q[3])
                pdir = 2;
            else if (!key_q[1])
                pdir = 3;
            else if (!key_q[2])
                pdir = 4;
        end
        if (int'(x) != ex || int'(y) != ey || colour != COLOUR_BLACK)
            value_error($sformatf("sprite %0d erase at (%0d,%0d) col %0d, want (%0d,%0d) black",
                sprite, x, y, colour, ex, ey));
    endtask

    task automatic check_draw(int sprite);
        int      nx;
        int      ny;
        colour_t col;
        if (sprite == 0)
        begin
            nx = px;
            ny = py;
            col = COLOUR_PLAYER;
            if (pdir == 1 || pdir == 2)
                nx = wrap_step(px, (pdir == 1) ? 1 : -1);
            else if (pdir == 3 && may_descend(px, py))
                ny = py + 1;
            else if (pdir == 4 && may_climb(px, py))
                ny = py - 1;
            px = nx;
            py = ny;
        end
        else
        begin
            nx = wrap_step(mx[sprite-1], MDIR[sprite-1]);
            ny = MY0[sprite-1];
            col = COLOUR_MINION;
            mx[sprite-1] = nx;
        end
        if (int'(x) != nx || int'(y) != ny || colour != col)
            value_error($sformatf("sprite %0d draw at (%0d,%0d) col %0d, want (%0d,%0d) col %0d",
                sprite, x, y, colour, nx, ny, col));
        apply_rules();
    endtask

    task automatic close_test(int num);
        if (errs == 0)
        begin
            pass_cnt++;
            $display("test %0d: pass", num);
        end
        else
        begin
            fail_cnt++;
            $display("test %0d: fail with %0d errors", num, errs);
        end
        errs = 0;
    endtask

    // tb signals change on falling edges, take them on the rising one
    always @(posedge clk)
    begin
        rst_q <= reset_n;
        key_q <= key;
        end_q <= case_end;
        num_q <= case_num;
        ex_q  <= exp_x;
        ey_q  <= exp_y;
        es_q  <= exp_score;
    end

    always @(negedge clk)
    begin
        int s;
        int sprite;
        int ph;
        logic want;
        if (!rst_q)
        begin
            n = 0;
            errs = 0;
            score = 0;
            pass_cnt = 0;
            fail_cnt = 0;
            pair_on = 1'b0;
            pdir = 0;
            restart_player();
            for (int k = 0; k < NUM; k++)
                mx[k] = MX0[k];
        end
        else
        begin
            n = n + 1;
            if (n < 3)
            begin
                if (plot)
                    plain_error("plot went high before the first tick");
                if (n == 2)
                begin
                    if (hex0 != seg_for(0) || hex1 != seg_for(0))
                        value_error($sformatf("digits after reset %h %h", hex1, hex0));
                    close_test(0);
                end
            end
            else
            begin
                s = (n - 3) % `TICK_PERIOD;
                sprite = s / `PHASE_STEP;
                ph = s % `PHASE_STEP;
                if (ph == 0 && sprite <= NUM)
                begin
                    want = (sprite != 0) || (key_q != 4'hf);  // player idles without a key
                    pair_on = want;
                    if (want && !plot)
                        plain_error($sformatf("erase plot of sprite %0d is missing", sprite));
                    else if (!want && plot)
                        plain_error("plot seen while the player had no key held");
                    else if (want)
                        check_erase(sprite);
                end
                else if (ph == 1 && sprite <= NUM && pair_on)
                begin
                    if (!plot)
                        plain_error($sformatf("draw plot of sprite %0d is missing", sprite));
                    else
                        check_draw(sprite);
                end
                else if (plot)
                    plain_error("plot seen outside any sprite slot");
            end

            if (end_q)
            begin
                if (int'(player_x) != ex_q || int'(player_y) != ey_q)
                    value_error($sformatf("player at (%0d,%0d), expected (%0d,%0d)",
                        player_x, player_y, ex_q, ey_q));
                if (px != ex_q || py != ey_q || score != es_q)
                    value_error($sformatf("model at (%0d,%0d) score %0d disagrees with case",
                        px, py, score));
                if (hex0 != seg_for(es_q % 10) || hex1 != seg_for(es_q / 10))
                    value_error($sformatf("digits %h %h, expected score %0d", hex1, hex0, es_q));
                close_test(num_q);
            end
        end
    end

endmodule

// ==== tb/tb_ladder_game.sv ====
`timescale 1ns/1ps
`include "ladder_macros.svh"

module tb_ladder_game import ladder_pkg::*;
();

    logic       clk;
    logic       reset_n;
    logic [3:0] key;
    logic       plot;
    coord_t     x;
    coord_t     y;
    colour_t    colour;
    logic [6:0] hex0;
    logic [6:0] hex1;
    coord_t     dut_px;
    coord_t     dut_py;
    logic       case_end;
    int         case_num;
    int         exp_x;
    int         exp_y;
    int         exp_score;
    int         pass_cnt;
    int         fail_cnt;
    logic [7:0] cases [0:127];  // key, ticks, x, y, score per case
    int         total_ticks;
    int         cycle_cnt;
    int         cycle_limit;
    int         idx;
    int         lag;

    ladder_game_top i_ladder_game_top (
        .clk     (clk),
        .reset_n (reset_n),
        .key     (key),
        .plot    (plot),
        .x       (x),
        .y       (y),
        .colour  (colour),
        .hex0    (hex0),
        .hex1    (hex1)
    );

    assign dut_px = i_ladder_game_top.player_x;
    assign dut_py = i_ladder_game_top.player_y;

    game_checker i_game_checker (
        .clk       (clk),
        .reset_n   (reset_n),
        .key       (key),
        .plot      (plot),
        .x         (x),
        .y         (y),
        .colour    (colour),
        .hex0      (hex0),
        .hex1      (hex1),
        .player_x  (dut_px),
        .player_y  (dut_py),
        .case_end  (case_end),
        .case_num  (case_num),
        .exp_x     (exp_x),
        .exp_y     (exp_y),
        .exp_score (exp_score),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    initial
    begin
        reset_n = 1'b0;
        key = 4'hf;
        case_end = 1'b0;
        case_num = 0;
        exp_x = 0;
        exp_y = 0;
        exp_score = 0;
        cycle_cnt = 0;
        cycle_limit = 0;
        total_ticks = 0;
        lag = 0;
        $readmemh("tb/game_cases.txt", cases);
        for (idx = 0; idx < 25 && cases[idx*5+1] != 8'd0; idx++)
            total_ticks += int'(cases[idx*5+1]);
        cycle_limit = (total_ticks + 4) * `TICK_PERIOD * 2;

        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        repeat (32) @(negedge clk);     // keys change mid period, away from ticks
        key = cases[0][3:0];
        idx = 0;
        while (cases[idx*5+1] != 8'd0)
        begin
            repeat (int'(cases[idx*5+1]) * `TICK_PERIOD - lag) @(negedge clk);
            case_num = idx + 1;
            exp_x = int'(cases[idx*5+2]);
            exp_y = int'(cases[idx*5+3]);
            exp_score = int'(cases[idx*5+4]);
            case_end = 1'b1;
            key = cases[idx*5+5][3:0];  // end line releases the keys
            @(negedge clk);
            case_end = 1'b0;
            lag = 1;
            idx++;
        end
        @(posedge clk);     // last test closes on the falling edge before

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== tb/game_cases.txt ====
// key ticks exp_x exp_y exp_score, all hex; key is active low, ticks 00 ends the list
b 02 05 75 00
e 03 08 75 00
f 02 08 75 00
7 09 7e 75 00
b 20 7e 55 00
e 11 10 55 00
b 1d 10 38 00
7 11 7e 38 00
b 1e 05 75 01
7 06 7e 75 01
b 0a 7e 6b 01
f 28 05 75 00
f 00 00 00 00

// ==== list.f ====
+incdir+design
design/ladder_pkg.sv
design/plot_if.sv
design/tick_gen.sv
design/player_mover.sv
design/minion_lane.sv
design/plot_arbiter.sv
design/score_keeper.sv
design/ladder_game_top.sv
tb/game_checker.sv
tb/tb_ladder_game.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ladder_game -f list.f -o sim_ladder \
    > build.log 2>&1 \
    && ./obj_dir/sim_ladder > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "sim failed" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
